//--- Bender.yml
package:
  name: mat_calc

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - hw/mat_pkg.sv
      - hw/calc_pkg.sv
      - hw/mat_store.sv
      - hw/calc_ctrl.sv
      - hw/mat_alu.sv
      - hw/result_tx.sv
      - hw/mat_calc_top.sv

  # Testbench, top module mat_calc_tb
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/mat_calc_tb.sv

//--- bench/mat_calc_tb.sv
`timescale 1ns/10ps

module mat_calc_tb;
  import mat_pkg::*;
  import calc_pkg::*;

  // ==========================================================
  // Run limits
  // ==========================================================
  localparam int NUM_TESTS   = 16;
  localparam int MAX_DELAY   = 15;
  // 16 elements of up to 4 products each plus slowest credits
  localparam int TEST_CYCLES = MAX_ROWS * MAX_COLS * 4 +
                               MAX_ROWS * MAX_COLS * MAX_DELAY + 32;
  // Two slot fills of one new-matrix write and 16 elements
  localparam int FILL_CYCLES = 2 * (MAX_ROWS * MAX_COLS + 1);
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (TEST_CYCLES + FILL_CYCLES + 8) + 100;

  // DUT signals
  logic     clk;
  logic     rst_n;
  logic     wr_new;
  logic     wr_single;
  slot_id_t wr_slot;
  dim_t     wr_rows;
  dim_t     wr_cols;
  row_idx_t wr_row;
  col_idx_t wr_col;
  elem_t    wr_data;
  logic     cmd_valid;
  op_t      cmd_op;
  slot_id_t cmd_id_a;
  slot_id_t cmd_id_b;
  elem_t    cmd_scalar;
  logic     res_credit;
  logic     busy;
  logic     done;
  logic     err;
  logic     res_valid;
  logic     res_last;
  res_t     res_data;

  // Stimulus table with one entry per command
  int       tab_rows_a [NUM_TESTS];
  int       tab_cols_a [NUM_TESTS];
  int       tab_rows_b [NUM_TESTS];
  int       tab_cols_b [NUM_TESTS];
  op_t      tab_op     [NUM_TESTS];
  slot_id_t tab_id_a   [NUM_TESTS];
  slot_id_t tab_id_b   [NUM_TESTS];
  elem_t    tab_scalar [NUM_TESTS];
  logic     tab_err    [NUM_TESTS];
  int       tab_mode   [NUM_TESTS];
  int       num_rows;

  // Reference copy of the storage
  elem_t model_mem  [NUM_SLOTS][MAX_ROWS][MAX_COLS];
  int    model_rows [NUM_SLOTS];
  int    model_cols [NUM_SLOTS];
  res_t  exp_q [$];
  // Cycle numbers at which credits go back
  int    credit_q [$];

  int          value_errs;
  int          flag_errs;
  int          count_errs;
  int          other_errs;
  int          cycle_count = 0;
  int          outstanding;
  int          peak_outstanding;
  int          cur_test;
  logic [31:0] lfsr_state;

  tb_clk_gen clk_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mat_calc_top mat_calc_top_inst (
    .clk(clk),               .rst_n(rst_n),
    .wr_new(wr_new),         .wr_single(wr_single),
    .wr_slot(wr_slot),       .wr_rows(wr_rows),       .wr_cols(wr_cols),
    .wr_row(wr_row),         .wr_col(wr_col),         .wr_data(wr_data),
    .cmd_valid(cmd_valid),   .cmd_op(cmd_op),
    .cmd_id_a(cmd_id_a),     .cmd_id_b(cmd_id_b),     .cmd_scalar(cmd_scalar),
    .res_credit(res_credit), .busy(busy),             .done(done),
    .err(err),               .res_valid(res_valid),   .res_last(res_last),
    .res_data(res_data)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ==========================================================
  // Random bits and checks
  // ==========================================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic check_res(input res_t got, input res_t exp, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED at %0t: test %0d %s: got %04h, expected %04h",
               $time, cur_test, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("CHECK FAILED at %0t: test %0d %s: got %b, expected %b",
               $time, cur_test, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      count_errs++;
      $display("CHECK FAILED at %0t: test %0d %s: got %0d, expected %0d",
               $time, cur_test, what, got, exp);
    end
  endtask

  // ==========================================================
  // Table and reference model
  // ==========================================================
  task automatic add_row(input int ra, input int ca, input int rb, input int cb,
                         input op_t op, input int ida, input int idb,
                         input int scalar, input logic exp_err, input int mode);
    tab_rows_a[num_rows] = ra;
    tab_cols_a[num_rows] = ca;
    tab_rows_b[num_rows] = rb;
    tab_cols_b[num_rows] = cb;
    tab_op[num_rows]     = op;
    tab_id_a[num_rows]   = slot_id_t'(ida);
    tab_id_b[num_rows]   = slot_id_t'(idb);
    tab_scalar[num_rows] = elem_t'(scalar);
    tab_err[num_rows]    = exp_err;
    tab_mode[num_rows]   = mode;
    num_rows++;
  endtask

  // Zero dims leave the slot untouched
  // Slot 3 is never written and stays empty
  // Credit mode 0 returns at once
  // Mode 1 within 3 cycles and mode 2 after 8 to 15
  task automatic load_table();
    num_rows = 0;
    //      ra ca rb cb  op            a  b  scalar err   mode
    add_row(2, 3, 2, 3, OP_ADD,       0, 1,   0, 1'b0, 0);
    add_row(3, 3, 3, 3, OP_SUB,       0, 1,   0, 1'b0, 1);
    add_row(4, 4, 4, 4, OP_ADD,       1, 2,   0, 1'b0, 2);
    add_row(1, 1, 1, 1, OP_SUB,       2, 0,   0, 1'b0, 0);
    add_row(3, 2, 0, 0, OP_SCALE,     0, 0, 200, 1'b0, 0);
    add_row(4, 4, 0, 0, OP_SCALE,     1, 0, 255, 1'b0, 2);
    add_row(2, 4, 0, 0, OP_TRANSPOSE, 2, 0,   0, 1'b0, 1);
    add_row(4, 1, 0, 0, OP_TRANSPOSE, 0, 0,   0, 1'b0, 2);
    add_row(1, 4, 4, 1, OP_MUL,       0, 1,   0, 1'b0, 0);
    add_row(4, 4, 4, 4, OP_MUL,       1, 2,   0, 1'b0, 1);
    add_row(2, 3, 3, 4, OP_MUL,       2, 0,   0, 1'b0, 2);
    add_row(4, 1, 1, 4, OP_MUL,       0, 1,   0, 1'b0, 0);
    // Error cases
    add_row(2, 3, 3, 2, OP_ADD,       0, 1,   0, 1'b1, 0);
    add_row(2, 3, 2, 3, OP_MUL,       1, 2,   0, 1'b1, 0);
    add_row(2, 2, 0, 0, OP_ADD,       0, 3,   0, 1'b1, 0);
    add_row(0, 0, 0, 0, OP_SCALE,     3, 0,   7, 1'b1, 0);
  endtask

  // Expected stream in row-major order modulo 2^16
  task automatic build_expected(input int idx);
    slot_id_t sa;
    slot_id_t sb;
    int       ra;
    int       ca;
    int       cb;
    int       sum;
    sa = tab_id_a[idx];
    sb = tab_id_b[idx];
    ra = model_rows[sa];
    ca = model_cols[sa];
    cb = model_cols[sb];
    exp_q.delete();
    if (!tab_err[idx]) begin
      case (tab_op[idx])
        OP_TRANSPOSE: begin
          // Shape swaps
          for (int r = 0; r < ca; r++) begin
            for (int c = 0; c < ra; c++) begin
              exp_q.push_back(res_t'(int'(model_mem[sa][c][r])));
            end
          end
        end
        OP_MUL: begin
          for (int r = 0; r < ra; r++) begin
            for (int c = 0; c < cb; c++) begin
              sum = 0;
              for (int k = 0; k < ca; k++) begin
                sum += int'(model_mem[sa][r][k]) * int'(model_mem[sb][k][c]);
              end
              exp_q.push_back(res_t'(sum));
            end
          end
        end
        default: begin
          for (int r = 0; r < ra; r++) begin
            for (int c = 0; c < ca; c++) begin
              if (tab_op[idx] == OP_ADD) begin
                sum = int'(model_mem[sa][r][c]) + int'(model_mem[sb][r][c]);
              end else if (tab_op[idx] == OP_SUB) begin
                sum = int'(model_mem[sa][r][c]) - int'(model_mem[sb][r][c]);
              end else begin
                sum = int'(model_mem[sa][r][c]) * int'(tab_scalar[idx]);
              end
              exp_q.push_back(res_t'(sum));
            end
          end
        end
      endcase
    end
  endtask

  // ==========================================================
  // Drivers
  // ==========================================================

  // New matrix followed by every element from the LFSR
  task automatic write_matrix(input slot_id_t slot, input int rows, input int cols);
    elem_t v;
    if (rows != 0) begin
      wr_new  <= 1'b1;
      wr_slot <= slot;
      wr_rows <= dim_t'(rows);
      wr_cols <= dim_t'(cols);
      @(posedge clk);
      wr_new <= 1'b0;
      model_rows[slot] = rows;
      model_cols[slot] = cols;
      for (int r = 0; r < rows; r++) begin
        for (int c = 0; c < cols; c++) begin
          v = elem_t'(take_bits(ELEM_W));
          model_mem[slot][r][c] = v;
          wr_single <= 1'b1;
          wr_row    <= row_idx_t'(r);
          wr_col    <= col_idx_t'(c);
          wr_data   <= v;
          @(posedge clk);
        end
      end
      wr_single <= 1'b0;
    end
  endtask

  // Credit for one received element due after a mode-dependent delay
  task automatic schedule_credit();
    int delay;
    int due;
    case (tab_mode[cur_test])
      0:       delay = 0;
      1:       delay = take_bits(2);
      default: delay = 8 + take_bits(3);
    endcase
    due = cycle_count + delay;
    // Keep queue in due order
    if (credit_q.size() > 0 && due < credit_q[credit_q.size() - 1]) begin
      due = credit_q[credit_q.size() - 1];
    end
    credit_q.push_back(due);
  endtask

  // At most one credit pulse per cycle
  task automatic drive_credit();
    if (credit_q.size() > 0 && credit_q[0] <= cycle_count) begin
      credit_q.delete(0);
      res_credit <= 1'b1;
      outstanding--;
    end else begin
      res_credit <= 1'b0;
    end
  endtask

  task automatic check_idle_after_reset();
    repeat (4) begin
      @(posedge clk);
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(done, 1'b0, "done after reset");
      check_flag(err, 1'b0, "err after reset");
      check_flag(res_valid, 1'b0, "res_valid before any command");
    end
  endtask

  // ==========================================================
  // One command and its result stream
  // ==========================================================
  task automatic run_command(input int idx);
    int   cyc;
    int   n;
    int   last_cyc;
    logic finished;
    check_flag(busy, 1'b0, "busy before command");
    cmd_valid  <= 1'b1;
    cmd_op     <= tab_op[idx];
    cmd_id_a   <= tab_id_a[idx];
    cmd_id_b   <= tab_id_b[idx];
    cmd_scalar <= tab_scalar[idx];
    // Acceptance edge
    @(posedge clk);
    cmd_valid <= 1'b0;
    cyc      = 0;
    n        = 0;
    last_cyc = -1;
    finished = 1'b0;
    while (!finished && cyc < TEST_CYCLES) begin
      @(posedge clk);
      cyc++;
      if (cyc == 1) check_flag(busy, 1'b1, "busy after accept");
      if (res_valid) begin
        outstanding++;
        if (outstanding > peak_outstanding) peak_outstanding = outstanding;
        if (n < exp_q.size()) begin
          check_res(res_data, exp_q[n], $sformatf("element %0d", n));
          check_flag(res_last, n == exp_q.size() - 1, $sformatf("res_last on %0d", n));
        end else begin
          check_flag(res_valid, 1'b0, "element beyond expected count");
        end
        if (res_last) last_cyc = cyc;
        n++;
        schedule_credit();
      end
      if (err) begin
        check_flag(err, tab_err[idx], "err pulse");
        check_count(cyc, 2, "err cycles after accept");
        finished = 1'b1;
      end
      if (done) begin
        check_flag(done, !tab_err[idx], "done pulse");
        check_count(cyc, last_cyc + 1, "done cycle after res_last");
        finished = 1'b1;
      end
      if (finished) check_flag(busy, 1'b0, "busy with done or err");
      drive_credit();
    end
    if (!finished) begin
      other_errs++;
      $display("ERROR: test %0d gave neither done nor err within %0d cycles",
               idx, TEST_CYCLES);
    end
    check_count(n, exp_q.size(), "element count");
    check_flag(peak_outstanding <= CREDIT_MAX, 1'b1, "outstanding within credits");
    // Return the rest of the credits while outputs stay quiet
    cyc = 0;
    while ((credit_q.size() > 0 || cyc < 3) && cyc < TEST_CYCLES) begin
      @(posedge clk);
      cyc++;
      check_flag(res_valid, 1'b0, "res_valid after end");
      check_flag(done, 1'b0, "done after end");
      check_flag(err, 1'b0, "err after end");
      drive_credit();
    end
    @(posedge clk);
    res_credit <= 1'b0;
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    int total;
    lfsr_state = 32'h2860_465d;
    wr_new     = 1'b0;
    wr_single  = 1'b0;
    wr_slot    = '0;
    wr_rows    = '0;
    wr_cols    = '0;
    wr_row     = '0;
    wr_col     = '0;
    wr_data    = '0;
    cmd_valid  = 1'b0;
    cmd_op     = OP_ADD;
    cmd_id_a   = '0;
    cmd_id_b   = '0;
    cmd_scalar = '0;
    res_credit = 1'b0;
    value_errs  = 0;
    flag_errs   = 0;
    count_errs  = 0;
    other_errs  = 0;
    outstanding = 0;
    cur_test    = -1;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      model_rows[s] = 0;
      model_cols[s] = 0;
    end
    load_table();
    wait (rst_n === 1'b1);
    @(posedge clk);
    check_idle_after_reset();
    for (int i = 0; i < num_rows; i++) begin
      cur_test         = i;
      peak_outstanding = 0;
      write_matrix(tab_id_a[i], tab_rows_a[i], tab_cols_a[i]);
      write_matrix(tab_id_b[i], tab_rows_b[i], tab_cols_b[i]);
      build_expected(i);
      run_command(i);
    end
    total = value_errs + flag_errs + count_errs + other_errs;
    $display("Errors: value %0d, flag %0d, count %0d, other %0d",
             value_errs, flag_errs, count_errs, other_errs);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Backstop for a run that stops making progress
  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    other_errs++;
    $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors: value %0d, flag %0d, count %0d, other %0d",
             value_errs, flag_errs, count_errs, other_errs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // Reset held low for the first 5 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- hw/calc_ctrl.sv
`timescale 1ns/10ps

module calc_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  // Command from outside
  input  logic              cmd_valid,
  input  calc_pkg::op_t     cmd_op,
  input  mat_pkg::slot_id_t cmd_id_a,
  input  mat_pkg::slot_id_t cmd_id_b,
  input  mat_pkg::elem_t    cmd_scalar,
  // Operand dimensions from storage
  input  mat_pkg::dim_t     rows_a,
  input  mat_pkg::dim_t     cols_a,
  input  mat_pkg::dim_t     rows_b,
  input  mat_pkg::dim_t     cols_b,
  // ALU handshake
  input  logic              run_done,
  output logic              run_start,
  output calc_pkg::op_t     run_op,
  output mat_pkg::slot_id_t run_id_a,
  output mat_pkg::slot_id_t run_id_b,
  output mat_pkg::elem_t    run_scalar,
  // Status
  output logic              busy,
  output logic              done,
  output logic              err
);
  import calc_pkg::*;

  ctrl_state_t state;
  logic        fail;
  logic        accept;
  logic        uses_b;
  logic        dims_bad;

  // FINISH is the report cycle, already free for a new command
  assign busy   = (state == ST_CHECK) || (state == ST_RUN);
  assign accept = cmd_valid && !busy;
  assign done   = (state == ST_FINISH) && !fail;
  assign err    = (state == ST_FINISH) && fail;

  // ==========================================================
  // Dimension rule on the latched command
  // ==========================================================
  always_comb begin
    uses_b   = (run_op == OP_ADD) || (run_op == OP_SUB) || (run_op == OP_MUL);
    dims_bad = (rows_a == '0) || (cols_a == '0);
    // B only matters for two-operand ops
    if (uses_b && ((rows_b == '0) || (cols_b == '0))) begin
      dims_bad = 1'b1;
    end
    case (run_op)
      OP_ADD, OP_SUB: begin
        if ((rows_a != rows_b) || (cols_a != cols_b)) dims_bad = 1'b1;
      end
      OP_MUL: begin
        // Inner dimensions must agree
        if (cols_a != rows_b) dims_bad = 1'b1;
      end
      default: ;
    endcase
  end

  // ==========================================================
  // Control FSM
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      fail      <= 1'b0;
      run_start <= 1'b0;
    end else begin
      run_start <= 1'b0;
      case (state)
        ST_IDLE, ST_FINISH: begin
          state <= accept ? ST_CHECK : ST_IDLE;
        end
        ST_CHECK: begin
          fail <= dims_bad;
          if (dims_bad) begin
            state <= ST_FINISH;
          end else begin
            state     <= ST_RUN;
            run_start <= 1'b1;
          end
        end
        ST_RUN: begin
          // Last element already on the output
          if (run_done) state <= ST_FINISH;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Command fields, held for the whole run
  always_ff @(posedge clk) begin
    if (accept) begin
      run_op     <= cmd_op;
      run_id_a   <= cmd_id_a;
      run_id_b   <= cmd_id_b;
      run_scalar <= cmd_scalar;
    end
  end

endmodule

//--- hw/calc_pkg.sv
package calc_pkg;

  // ==========================================================
  // Command encodings
  // ==========================================================

  // ALU operations
  typedef enum logic [2:0] {
    OP_ADD       = 3'd0,
    OP_SUB       = 3'd1,
    OP_SCALE     = 3'd2,
    OP_TRANSPOSE = 3'd3,
    OP_MUL       = 3'd4
  } op_t;

  // Controller FSM
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_CHECK  = 2'd1,
    ST_RUN    = 2'd2,
    ST_FINISH = 2'd3
  } ctrl_state_t;

  // Credits granted by the receiver after reset
  localparam int CREDIT_MAX = 4;
  localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

endpackage

//--- hw/mat_alu.sv
`timescale 1ns/10ps

module mat_alu (
  input  logic              clk,
  input  logic              rst_n,
  // Run request from the controller
  input  logic              run_start,
  input  calc_pkg::op_t     run_op,
  input  mat_pkg::slot_id_t run_id_a,
  input  mat_pkg::slot_id_t run_id_b,
  input  mat_pkg::elem_t    run_scalar,
  // Operand shape and data
  input  mat_pkg::dim_t     rows_a,
  input  mat_pkg::dim_t     cols_a,
  input  mat_pkg::dim_t     cols_b,
  input  mat_pkg::elem_t    rd_data_a,
  input  mat_pkg::elem_t    rd_data_b,
  output mat_pkg::slot_id_t rd_id_a,
  output mat_pkg::slot_id_t rd_id_b,
  output mat_pkg::row_idx_t rd_row_a,
  output mat_pkg::row_idx_t rd_row_b,
  output mat_pkg::col_idx_t rd_col_a,
  output mat_pkg::col_idx_t rd_col_b,
  // Element stream
  input  logic              can_push,
  output logic              elem_push,
  output logic              elem_last,
  output mat_pkg::res_t     elem_data,
  output logic              run_done
);
  import mat_pkg::*;
  import calc_pkg::*;

  logic     active;
  op_t      op_q;
  elem_t    scalar_q;
  row_idx_t row;
  col_idx_t col;
  col_idx_t k;
  res_t     acc;
  res_t     product;
  dim_t     out_rows;
  dim_t     out_cols;
  logic     row_end;
  logic     col_end;
  logic     k_end;
  logic     elem_ready;

  // Slot ids stay stable from the controller
  assign rd_id_a = run_id_a;
  assign rd_id_b = run_id_b;

  // Result shape per op
  always_comb begin
    case (op_q)
      OP_TRANSPOSE: begin
        out_rows = cols_a;
        out_cols = rows_a;
      end
      OP_MUL: begin
        out_rows = rows_a;
        out_cols = cols_b;
      end
      default: begin
        out_rows = rows_a;
        out_cols = cols_a;
      end
    endcase
  end

  assign row_end    = (dim_t'(row) == out_rows - dim_t'(1));
  assign col_end    = (dim_t'(col) == out_cols - dim_t'(1));
  assign k_end      = (dim_t'(k) == cols_a - dim_t'(1));
  // MUL element ready on its last product
  assign elem_ready = (op_q != OP_MUL) || k_end;
  assign elem_push  = active && elem_ready && can_push;
  assign elem_last  = row_end && col_end;

  // ==========================================================
  // Operand addressing and element value
  // ==========================================================
  always_comb begin
    rd_row_a = row;
    rd_col_a = col;
    rd_row_b = row;
    rd_col_b = col;
    case (op_q)
      OP_TRANSPOSE: begin
        rd_row_a = row_idx_t'(col);
        rd_col_a = col_idx_t'(row);
      end
      OP_MUL: begin
        // A walks its row, B walks its column
        rd_col_a = k;
        rd_row_b = row_idx_t'(k);
      end
      default: ;
    endcase
  end

  assign product = res_t'(rd_data_a) * res_t'(rd_data_b);

  always_comb begin
    case (op_q)
      OP_ADD:       elem_data = res_t'(rd_data_a) + res_t'(rd_data_b);
      OP_SUB:       elem_data = res_t'(rd_data_a) - res_t'(rd_data_b);
      OP_SCALE:     elem_data = res_t'(rd_data_a) * res_t'(scalar_q);
      OP_TRANSPOSE: elem_data = res_t'(rd_data_a);
      OP_MUL:       elem_data = acc + product;
      default:      elem_data = '0;
    endcase
  end

  // ==========================================================
  // Position counters
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      op_q     <= OP_ADD;
      row      <= '0;
      col      <= '0;
      k        <= '0;
      run_done <= 1'b0;
    end else begin
      run_done <= elem_push && elem_last;
      if (run_start) begin
        active <= 1'b1;
        op_q   <= run_op;
        row    <= '0;
        col    <= '0;
        k      <= '0;
      end else if (elem_push) begin
        k <= '0;
        if (col_end) begin
          col <= '0;
          row <= row + 1'b1;
          // Row-major walk ends here
          if (row_end) active <= 1'b0;
        end else begin
          col <= col + 1'b1;
        end
      end else if (active && (op_q == OP_MUL) && !k_end) begin
        k <= k + 1'b1;
      end
    end
  end

  // Scalar and running sum
  always_ff @(posedge clk) begin
    if (run_start) begin
      scalar_q <= run_scalar;
      acc      <= '0;
    end else if (elem_push) begin
      acc <= '0;
    end else if (active && (op_q == OP_MUL) && !k_end) begin
      acc <= acc + product;
    end
  end

endmodule

//--- hw/mat_calc_top.sv
`timescale 1ns/10ps

module mat_calc_top (
  input  logic              clk,
  input  logic              rst_n,
  // Storage writes
  input  logic              wr_new,
  input  logic              wr_single,
  input  mat_pkg::slot_id_t wr_slot,
  input  mat_pkg::dim_t     wr_rows,
  input  mat_pkg::dim_t     wr_cols,
  input  mat_pkg::row_idx_t wr_row,
  input  mat_pkg::col_idx_t wr_col,
  input  mat_pkg::elem_t    wr_data,
  // Commands
  input  logic              cmd_valid,
  input  calc_pkg::op_t     cmd_op,
  input  mat_pkg::slot_id_t cmd_id_a,
  input  mat_pkg::slot_id_t cmd_id_b,
  input  mat_pkg::elem_t    cmd_scalar,
  // Result stream
  input  logic              res_credit,
  output logic              busy,
  output logic              done,
  output logic              err,
  output logic              res_valid,
  output logic              res_last,
  output mat_pkg::res_t     res_data
);

  // ==========================================================
  // Interconnect
  // ==========================================================

  // Controller to ALU
  logic              run_start;
  logic              run_done;
  calc_pkg::op_t     run_op;
  mat_pkg::slot_id_t run_id_a;
  mat_pkg::slot_id_t run_id_b;
  mat_pkg::elem_t    run_scalar;

  // ALU to storage
  mat_pkg::slot_id_t rd_id_a;
  mat_pkg::slot_id_t rd_id_b;
  mat_pkg::row_idx_t rd_row_a;
  mat_pkg::row_idx_t rd_row_b;
  mat_pkg::col_idx_t rd_col_a;
  mat_pkg::col_idx_t rd_col_b;
  mat_pkg::elem_t    rd_data_a;
  mat_pkg::elem_t    rd_data_b;
  mat_pkg::dim_t     rows_a;
  mat_pkg::dim_t     cols_a;
  mat_pkg::dim_t     rows_b;
  mat_pkg::dim_t     cols_b;

  // ALU to output stage
  logic              can_push;
  logic              elem_push;
  logic              elem_last;
  mat_pkg::res_t     elem_data;

  // Writes held off while a command runs
  mat_store u_store (
    .clk(clk),             .rst_n(rst_n),
    .wr_new(wr_new),       .wr_single(wr_single),
    .wr_slot(wr_slot),     .wr_rows(wr_rows),       .wr_cols(wr_cols),
    .wr_row(wr_row),       .wr_col(wr_col),         .wr_data(wr_data),
    .wr_block(busy),
    .rd_id_a(rd_id_a),     .rd_id_b(rd_id_b),
    .rd_row_a(rd_row_a),   .rd_row_b(rd_row_b),
    .rd_col_a(rd_col_a),   .rd_col_b(rd_col_b),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .rows_a(rows_a),       .cols_a(cols_a),
    .rows_b(rows_b),       .cols_b(cols_b)
  );

  calc_ctrl u_ctrl (
    .clk(clk),             .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .cmd_id_a(cmd_id_a),   .cmd_id_b(cmd_id_b),     .cmd_scalar(cmd_scalar),
    .rows_a(rows_a),       .cols_a(cols_a),
    .rows_b(rows_b),       .cols_b(cols_b),
    .run_done(run_done),   .run_start(run_start),   .run_op(run_op),
    .run_id_a(run_id_a),   .run_id_b(run_id_b),     .run_scalar(run_scalar),
    .busy(busy),           .done(done),             .err(err)
  );

  mat_alu u_alu (
    .clk(clk),             .rst_n(rst_n),
    .run_start(run_start), .run_op(run_op),
    .run_id_a(run_id_a),   .run_id_b(run_id_b),     .run_scalar(run_scalar),
    .rows_a(rows_a),       .cols_a(cols_a),         .cols_b(cols_b),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .rd_id_a(rd_id_a),     .rd_id_b(rd_id_b),
    .rd_row_a(rd_row_a),   .rd_row_b(rd_row_b),
    .rd_col_a(rd_col_a),   .rd_col_b(rd_col_b),
    .can_push(can_push),   .elem_push(elem_push),   .elem_last(elem_last),
    .elem_data(elem_data), .run_done(run_done)
  );

  result_tx u_tx (
    .clk(clk),             .rst_n(rst_n),
    .elem_push(elem_push), .elem_last(elem_last),   .elem_data(elem_data),
    .can_push(can_push),   .res_credit(res_credit),
    .res_valid(res_valid), .res_last(res_last),     .res_data(res_data)
  );

endmodule

//--- hw/mat_pkg.sv
package mat_pkg;

  // ==========================================================
  // Matrix geometry
  // ==========================================================

  // Largest matrix held in one slot
  localparam int MAX_ROWS  = 4;
  localparam int MAX_COLS  = 4;

  // Number of stored matrices
  localparam int NUM_SLOTS = 4;

  // Stored element and result widths, both unsigned
  localparam int ELEM_W    = 8;
  localparam int RES_W     = 16;

  // ==========================================================
  // Types
  // ==========================================================

  // Element position inside a slot
  typedef logic [$clog2(MAX_ROWS)-1:0]   row_idx_t;
  typedef logic [$clog2(MAX_COLS)-1:0]   col_idx_t;

  // Dimension 1..4, zero marks an empty slot
  typedef logic [$clog2(MAX_ROWS+1)-1:0] dim_t;

  typedef logic [$clog2(NUM_SLOTS)-1:0]  slot_id_t;
  typedef logic [ELEM_W-1:0]             elem_t;
  // Results wrap modulo 2^RES_W
  typedef logic [RES_W-1:0]              res_t;

endpackage

//--- hw/mat_store.sv
`timescale 1ns/10ps

module mat_store (
  input  logic              clk,
  input  logic              rst_n,
  // Write side
  input  logic              wr_new,
  input  logic              wr_single,
  input  mat_pkg::slot_id_t wr_slot,
  input  mat_pkg::dim_t     wr_rows,
  input  mat_pkg::dim_t     wr_cols,
  input  mat_pkg::row_idx_t wr_row,
  input  mat_pkg::col_idx_t wr_col,
  input  mat_pkg::elem_t    wr_data,
  input  logic              wr_block,
  // Two element read ports
  input  mat_pkg::slot_id_t rd_id_a,
  input  mat_pkg::slot_id_t rd_id_b,
  input  mat_pkg::row_idx_t rd_row_a,
  input  mat_pkg::row_idx_t rd_row_b,
  input  mat_pkg::col_idx_t rd_col_a,
  input  mat_pkg::col_idx_t rd_col_b,
  output mat_pkg::elem_t    rd_data_a,
  output mat_pkg::elem_t    rd_data_b,
  // Dimensions of the read slots
  output mat_pkg::dim_t     rows_a,
  output mat_pkg::dim_t     cols_a,
  output mat_pkg::dim_t     rows_b,
  output mat_pkg::dim_t     cols_b
);
  import mat_pkg::*;

  elem_t mem    [NUM_SLOTS][MAX_ROWS][MAX_COLS];
  dim_t  rows_q [NUM_SLOTS];
  dim_t  cols_q [NUM_SLOTS];
  logic  new_ok;
  logic  single_ok;

  // New matrix needs both dims in 1..MAX
  assign new_ok = wr_new && !wr_block &&
                  (wr_rows != '0) && (wr_rows <= dim_t'(MAX_ROWS)) &&
                  (wr_cols != '0) && (wr_cols <= dim_t'(MAX_COLS));

  // Single element must fall inside the slot
  assign single_ok = wr_single && !wr_block &&
                     (dim_t'(wr_row) < rows_q[wr_slot]) &&
                     (dim_t'(wr_col) < cols_q[wr_slot]);

  // Per-slot dimensions, zero means empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        rows_q[s] <= '0;
        cols_q[s] <= '0;
      end
    end else if (new_ok) begin
      rows_q[wr_slot] <= wr_rows;
      cols_q[wr_slot] <= wr_cols;
    end
  end

  // Element array
  always_ff @(posedge clk) begin
    if (new_ok) begin
      // Fresh matrix starts all zero
      for (int r = 0; r < MAX_ROWS; r++) begin
        for (int c = 0; c < MAX_COLS; c++) begin
          mem[wr_slot][r][c] <= '0;
        end
      end
    end else if (single_ok) begin
      mem[wr_slot][wr_row][wr_col] <= wr_data;
    end
  end

  // Combinational reads
  assign rd_data_a = mem[rd_id_a][rd_row_a][rd_col_a];
  assign rd_data_b = mem[rd_id_b][rd_row_b][rd_col_b];
  assign rows_a    = rows_q[rd_id_a];
  assign cols_a    = cols_q[rd_id_a];
  assign rows_b    = rows_q[rd_id_b];
  assign cols_b    = cols_q[rd_id_b];

endmodule

//--- hw/result_tx.sv
`timescale 1ns/10ps

module result_tx (
  input  logic          clk,
  input  logic          rst_n,
  // From the ALU
  input  logic          elem_push,
  input  logic          elem_last,
  input  mat_pkg::res_t elem_data,
  output logic          can_push,
  // Credit stream to the receiver
  input  logic          res_credit,
  output logic          res_valid,
  output logic          res_last,
  output mat_pkg::res_t res_data
);
  import calc_pkg::*;

  logic [CREDIT_W-1:0] credits;
  logic [CREDIT_W-1:0] avail;

  // Element on the output already owns a credit
  assign avail    = credits - CREDIT_W'(res_valid);
  assign can_push = (avail != '0);

  // Output flags and credit counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits   <= CREDIT_W'(CREDIT_MAX);
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end else begin
      res_valid <= elem_push;
      res_last  <= elem_push && elem_last;
      // Spend on send, refund on return
      case ({res_valid, res_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  // Output data
  always_ff @(posedge clk) begin
    if (elem_push) res_data <= elem_data;
  end

endmodule

//--- mat_calc_top.f
hw/mat_pkg.sv
hw/calc_pkg.sv
hw/mat_store.sv
hw/calc_ctrl.sv
hw/mat_alu.sv
hw/result_tx.sv
hw/mat_calc_top.sv
bench/tb_clk_gen.sv
bench/mat_calc_tb.sv
